// ==== Bender.yml ====
package:
  name: hbus_bridge

sources:
  - target: rtl
    files:
      - src/hbus_pkg.sv
      - src/hbus_beat_seq.sv
      - src/hyperbus_fifo.sv
      - src/hyperbus_wishbone.sv
      - src/hbus_bridge_top.sv

  - target: test
    files:
      - test/hbus_mem_model.sv
      - test/tb_hbus_bridge.sv

// ==== hbus_bridge.f ====
src/hbus_pkg.sv
src/hbus_beat_seq.sv
src/hyperbus_fifo.sv
src/hyperbus_wishbone.sv
src/hbus_bridge_top.sv
test/hbus_mem_model.sv
test/tb_hbus_bridge.sv

// ==== src/hbus_beat_seq.sv ====
`default_nettype none

module hbus_beat_seq #(
  parameter int WB_DATA_WIDTH   = hbus_pkg::DEF_WB_DATA_WIDTH,
  parameter int WB_ADDR_WIDTH   = hbus_pkg::DEF_WB_ADDR_WIDTH,
  parameter int HBUS_ADDR_WIDTH = hbus_pkg::DEF_HBUS_ADDR_WIDTH,
  parameter int HBUS_DATA_WIDTH = hbus_pkg::DEF_HBUS_DATA_WIDTH
) (
  input  wire logic                         wb_clk,
  input  wire logic                         wb_rst,
  input  wire logic                         seq_valid_i,
  input  wire hbus_pkg::hbus_op_e           seq_op_i,
  input  wire logic [WB_ADDR_WIDTH-3:0]     seq_adr_i,
  input  wire logic [WB_DATA_WIDTH-1:0]     seq_wdat_i,
  input  wire logic [WB_DATA_WIDTH/8-1:0]   seq_sel_i,
  input  wire logic [HBUS_DATA_WIDTH-1:0]   hbus_dat_i,
  input  wire logic                         hbus_ready_i,
  input  wire logic                         hbus_valid_i,
  input  wire logic                         hbus_busy_i,
  output logic                              seq_done_o,
  output logic      [WB_DATA_WIDTH-1:0]     seq_rdat_o,
  output logic      [HBUS_ADDR_WIDTH-1:0]   hbus_adr_o,
  output logic      [HBUS_DATA_WIDTH-1:0]   hbus_dat_o,
  output logic      [HBUS_DATA_WIDTH/8-1:0] hbus_be_o,
  output logic                              hbus_rrq_o,
  output logic                              hbus_wrq_o
);

  localparam int BE_W = HBUS_DATA_WIDTH / 8;

  hbus_pkg::seq_state_e state;

  logic is_write;
  logic beat_hi;
  logic beat_active;
  logic beat_resp;

  assign is_write    = (seq_op_i == hbus_pkg::OP_WRITE);
  assign beat_hi     = (state == hbus_pkg::SEQ_HI);
  assign beat_active = hbus_rrq_o || hbus_wrq_o;

  // Writes finish on a ready pulse, reads on a valid pulse with data
  assign beat_resp = is_write ? hbus_ready_i : hbus_valid_i;

  // Halfword address is the word address times two plus the beat index
  assign hbus_adr_o = HBUS_ADDR_WIDTH'({seq_adr_i, beat_hi});
  assign hbus_dat_o = beat_hi ? seq_wdat_i[HBUS_DATA_WIDTH +: HBUS_DATA_WIDTH]
                              : seq_wdat_i[HBUS_DATA_WIDTH-1:0];
  assign hbus_be_o  = beat_hi ? seq_sel_i[BE_W +: BE_W] : seq_sel_i[BE_W-1:0];

  assign seq_done_o = (state == hbus_pkg::SEQ_DONE);

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state      <= hbus_pkg::SEQ_IDLE;
      hbus_rrq_o <= 1'b0;
      hbus_wrq_o <= 1'b0;
    end else begin
      case (state)
        hbus_pkg::SEQ_IDLE: begin
          if (seq_valid_i) begin
            state <= hbus_pkg::SEQ_LO;
          end
        end
        hbus_pkg::SEQ_LO, hbus_pkg::SEQ_HI: begin
          if (!beat_active) begin
            // Each beat waits for its own gap in the device's busy time
            if (!hbus_busy_i) begin
              hbus_wrq_o <= is_write;
              hbus_rrq_o <= !is_write;
            end
          end else if (beat_resp) begin
            hbus_wrq_o <= 1'b0;
            hbus_rrq_o <= 1'b0;
            state <= beat_hi ? hbus_pkg::SEQ_DONE : hbus_pkg::SEQ_HI;
          end
        end
        hbus_pkg::SEQ_DONE: state <= hbus_pkg::SEQ_IDLE;
        default:            state <= hbus_pkg::SEQ_IDLE;
      endcase
    end
  end

  // Gather the two read halves, low half first
  always_ff @(posedge wb_clk) begin
    if (beat_active && beat_resp && !is_write) begin
      if (beat_hi) begin
        seq_rdat_o[HBUS_DATA_WIDTH +: HBUS_DATA_WIDTH] <= hbus_dat_i;
      end else begin
        seq_rdat_o[HBUS_DATA_WIDTH-1:0] <= hbus_dat_i;
      end
    end
  end

  // Address, data and byte enables stay steady until the device answers
  a_beat_steady: assert property (@(posedge wb_clk) disable iff (wb_rst)
    beat_active && !beat_resp |=>
      $stable(hbus_adr_o) && $stable(hbus_dat_o) && $stable(hbus_be_o));

endmodule

`default_nettype wire

// ==== src/hbus_bridge_top.sv ====
`default_nettype none

module hbus_bridge_top #(
  parameter int WB_DATA_WIDTH   = hbus_pkg::DEF_WB_DATA_WIDTH,
  parameter int WB_ADDR_WIDTH   = hbus_pkg::DEF_WB_ADDR_WIDTH,
  parameter int HBUS_ADDR_WIDTH = hbus_pkg::DEF_HBUS_ADDR_WIDTH,
  parameter int HBUS_DATA_WIDTH = hbus_pkg::DEF_HBUS_DATA_WIDTH,
  parameter int FIFO_DEPTH      = hbus_pkg::DEF_FIFO_DEPTH
) (
  input  wire logic                         wb_clk,
  input  wire logic                         wb_rst,
  input  wire logic [WB_ADDR_WIDTH-1:0]     wb_adr_i,
  input  wire logic [WB_DATA_WIDTH-1:0]     wb_dat_i,
  input  wire logic                         wb_we_i,
  input  wire logic [WB_DATA_WIDTH/8-1:0]   wb_sel_i,
  input  wire logic                         wb_cyc_i,
  input  wire logic                         wb_stb_i,
  output logic      [WB_DATA_WIDTH-1:0]     wb_dat_o,
  output logic                              wb_ack_o,
  output logic                              wb_err_o,

  output logic      [HBUS_ADDR_WIDTH-1:0]   hbus_adr_o,
  output logic      [HBUS_DATA_WIDTH-1:0]   hbus_dat_o,
  output logic      [HBUS_DATA_WIDTH/8-1:0] hbus_be_o,
  output logic                              hbus_rrq_o,
  output logic                              hbus_wrq_o,
  input  wire logic [HBUS_DATA_WIDTH-1:0]   hbus_dat_i,
  input  wire logic                         hbus_ready_i,
  input  wire logic                         hbus_valid_i,
  input  wire logic                         hbus_busy_i
);

  hyperbus_wishbone #(
    .WB_DATA_WIDTH   (WB_DATA_WIDTH),
    .WB_ADDR_WIDTH   (WB_ADDR_WIDTH),
    .HBUS_ADDR_WIDTH (HBUS_ADDR_WIDTH),
    .HBUS_DATA_WIDTH (HBUS_DATA_WIDTH),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) u_wishbone (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .wb_sel_i     (wb_sel_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_be_o    (hbus_be_o),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i),
    .hbus_busy_i  (hbus_busy_i)
  );

endmodule

`default_nettype wire

// ==== src/hbus_pkg.sv ====
`default_nettype none

package hbus_pkg;

  // Direction of one bridge command
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } hbus_op_e;

  // Wishbone side of the four-phase request toward the command FIFO
  typedef enum logic [2:0] {
    WB_IDLE    = 3'd0,
    WB_REQ     = 3'd1,
    WB_RELEASE = 3'd2,
    WB_ACK     = 3'd3,
    WB_ERR     = 3'd4
  } wb_state_e;

  // One command is always two device beats, low half first
  typedef enum logic [2:0] {
    SEQ_IDLE = 3'd0,
    SEQ_LO   = 3'd1,
    SEQ_HI   = 3'd2,
    SEQ_DONE = 3'd3
  } seq_state_e;

  localparam int DEF_WB_DATA_WIDTH   = 32;
  localparam int DEF_WB_ADDR_WIDTH   = 32;
  localparam int DEF_HBUS_ADDR_WIDTH = 32;
  localparam int DEF_HBUS_DATA_WIDTH = 16;

  // Must be a power of two, 2 or more
  localparam int DEF_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// ==== src/hyperbus_fifo.sv ====
`default_nettype none

module hyperbus_fifo #(
  parameter int WB_DATA_WIDTH   = hbus_pkg::DEF_WB_DATA_WIDTH,
  parameter int WB_ADDR_WIDTH   = hbus_pkg::DEF_WB_ADDR_WIDTH,
  parameter int HBUS_ADDR_WIDTH = hbus_pkg::DEF_HBUS_ADDR_WIDTH,
  parameter int HBUS_DATA_WIDTH = hbus_pkg::DEF_HBUS_DATA_WIDTH,
  parameter int FIFO_DEPTH      = hbus_pkg::DEF_FIFO_DEPTH
) (
  input  wire logic                         wb_clk,
  input  wire logic                         wb_rst,
  input  wire logic                         cmd_req_i,
  input  wire hbus_pkg::hbus_op_e           cmd_op_i,
  input  wire logic [WB_ADDR_WIDTH-3:0]     cmd_adr_i,
  input  wire logic [WB_DATA_WIDTH-1:0]     cmd_wdat_i,
  input  wire logic [WB_DATA_WIDTH/8-1:0]   cmd_sel_i,
  output logic                              cmd_ack_o,
  output logic      [WB_DATA_WIDTH-1:0]     rsp_dat_o,

  output logic      [HBUS_ADDR_WIDTH-1:0]   hbus_adr_o,
  output logic      [HBUS_DATA_WIDTH-1:0]   hbus_dat_o,
  output logic      [HBUS_DATA_WIDTH/8-1:0] hbus_be_o,
  output logic                              hbus_rrq_o,
  output logic                              hbus_wrq_o,
  input  wire logic [HBUS_DATA_WIDTH-1:0]   hbus_dat_i,
  input  wire logic                         hbus_ready_i,
  input  wire logic                         hbus_valid_i,
  input  wire logic                         hbus_busy_i
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  hbus_pkg::hbus_op_e         op_mem   [FIFO_DEPTH];
  logic [WB_ADDR_WIDTH-3:0]   adr_mem  [FIFO_DEPTH];
  logic [WB_DATA_WIDTH-1:0]   wdat_mem [FIFO_DEPTH];
  logic [WB_DATA_WIDTH/8-1:0] sel_mem  [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  logic             seq_done;
  logic [WB_DATA_WIDTH-1:0] seq_rdat;

  assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign empty = (count == '0);

  // A read enters only into an empty buffer, so all earlier writes have drained
  assign push = cmd_req_i && !cmd_ack_o &&
                ((cmd_op_i == hbus_pkg::OP_WRITE) ? !full : empty);
  assign pop  = seq_done;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      cmd_ack_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);

      if (!cmd_req_i) begin
        cmd_ack_o <= 1'b0;
      end else if (push && cmd_op_i == hbus_pkg::OP_WRITE) begin
        cmd_ack_o <= 1'b1;
      end else if (pop && op_mem[rd_ptr] == hbus_pkg::OP_READ) begin
        cmd_ack_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk) begin
    if (push) begin
      op_mem[wr_ptr]   <= cmd_op_i;
      adr_mem[wr_ptr]  <= cmd_adr_i;
      wdat_mem[wr_ptr] <= cmd_wdat_i;
      sel_mem[wr_ptr]  <= cmd_sel_i;
    end
    // Read data stays valid until the next read completes
    if (pop && op_mem[rd_ptr] == hbus_pkg::OP_READ) begin
      rsp_dat_o <= seq_rdat;
    end
  end

  hbus_beat_seq #(
    .WB_DATA_WIDTH   (WB_DATA_WIDTH),
    .WB_ADDR_WIDTH   (WB_ADDR_WIDTH),
    .HBUS_ADDR_WIDTH (HBUS_ADDR_WIDTH),
    .HBUS_DATA_WIDTH (HBUS_DATA_WIDTH)
  ) u_beat_seq (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .seq_valid_i  (!empty),
    .seq_op_i     (op_mem[rd_ptr]),
    .seq_adr_i    (adr_mem[rd_ptr]),
    .seq_wdat_i   (wdat_mem[rd_ptr]),
    .seq_sel_i    (sel_mem[rd_ptr]),
    .seq_done_o   (seq_done),
    .seq_rdat_o   (seq_rdat),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_be_o    (hbus_be_o),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i),
    .hbus_busy_i  (hbus_busy_i)
  );

  // Read data always goes back to a request that is still waiting
  a_rd_req_live: assert property (@(posedge wb_clk) disable iff (wb_rst)
    pop && op_mem[rd_ptr] == hbus_pkg::OP_READ |-> cmd_req_i);
  a_no_pop_empty: assert property (@(posedge wb_clk) disable iff (wb_rst) !(pop && empty));

endmodule

`default_nettype wire

// ==== src/hyperbus_wishbone.sv ====
`default_nettype none

module hyperbus_wishbone #(
  parameter int WB_DATA_WIDTH   = hbus_pkg::DEF_WB_DATA_WIDTH,
  parameter int WB_ADDR_WIDTH   = hbus_pkg::DEF_WB_ADDR_WIDTH,
  parameter int HBUS_ADDR_WIDTH = hbus_pkg::DEF_HBUS_ADDR_WIDTH,
  parameter int HBUS_DATA_WIDTH = hbus_pkg::DEF_HBUS_DATA_WIDTH,
  parameter int FIFO_DEPTH      = hbus_pkg::DEF_FIFO_DEPTH
) (
  input  wire logic                         wb_clk,
  input  wire logic                         wb_rst,
  input  wire logic [WB_ADDR_WIDTH-1:0]     wb_adr_i,
  input  wire logic [WB_DATA_WIDTH-1:0]     wb_dat_i,
  input  wire logic                         wb_we_i,
  input  wire logic [WB_DATA_WIDTH/8-1:0]   wb_sel_i,
  input  wire logic                         wb_cyc_i,
  input  wire logic                         wb_stb_i,
  output logic      [WB_DATA_WIDTH-1:0]     wb_dat_o,
  output logic                              wb_ack_o,
  output logic                              wb_err_o,

  output logic      [HBUS_ADDR_WIDTH-1:0]   hbus_adr_o,
  output logic      [HBUS_DATA_WIDTH-1:0]   hbus_dat_o,
  output logic      [HBUS_DATA_WIDTH/8-1:0] hbus_be_o,
  output logic                              hbus_rrq_o,
  output logic                              hbus_wrq_o,
  input  wire logic [HBUS_DATA_WIDTH-1:0]   hbus_dat_i,
  input  wire logic                         hbus_ready_i,
  input  wire logic                         hbus_valid_i,
  input  wire logic                         hbus_busy_i
);

  hbus_pkg::wb_state_e state;

  logic                        cmd_req;
  logic                        cmd_ack;
  hbus_pkg::hbus_op_e          cmd_op;
  logic                        misaligned;

  // The master holds its inputs until ack or err, so they feed the FIFO directly
  assign cmd_op     = wb_we_i ? hbus_pkg::OP_WRITE : hbus_pkg::OP_READ;
  assign misaligned = |wb_adr_i[1:0];
  assign cmd_req    = (state == hbus_pkg::WB_REQ);

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state <= hbus_pkg::WB_IDLE;
    end else begin
      case (state)
        hbus_pkg::WB_IDLE: begin
          // A new request only starts once the previous ack has fallen
          if (wb_cyc_i && wb_stb_i && !cmd_ack) begin
            state <= misaligned ? hbus_pkg::WB_ERR : hbus_pkg::WB_REQ;
          end
        end
        hbus_pkg::WB_REQ: begin
          if (cmd_ack) begin
            state <= hbus_pkg::WB_RELEASE;
          end
        end
        hbus_pkg::WB_RELEASE: state <= hbus_pkg::WB_ACK;
        hbus_pkg::WB_ACK:     state <= hbus_pkg::WB_IDLE;
        hbus_pkg::WB_ERR:     state <= hbus_pkg::WB_IDLE;
        default:              state <= hbus_pkg::WB_IDLE;
      endcase
    end
  end

  assign wb_ack_o = (state == hbus_pkg::WB_ACK);
  assign wb_err_o = (state == hbus_pkg::WB_ERR);

  hyperbus_fifo #(
    .WB_DATA_WIDTH   (WB_DATA_WIDTH),
    .WB_ADDR_WIDTH   (WB_ADDR_WIDTH),
    .HBUS_ADDR_WIDTH (HBUS_ADDR_WIDTH),
    .HBUS_DATA_WIDTH (HBUS_DATA_WIDTH),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) u_fifo (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .cmd_req_i    (cmd_req),
    .cmd_op_i     (cmd_op),
    .cmd_adr_i    (wb_adr_i[WB_ADDR_WIDTH-1:2]),
    .cmd_wdat_i   (wb_dat_i),
    .cmd_sel_i    (wb_sel_i),
    .cmd_ack_o    (cmd_ack),
    .rsp_dat_o    (wb_dat_o),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_be_o    (hbus_be_o),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i),
    .hbus_busy_i  (hbus_busy_i)
  );

  // A response only goes out while the master still holds its cycle
  a_resp_in_cycle: assert property (@(posedge wb_clk) disable iff (wb_rst)
    (wb_ack_o || wb_err_o) |-> (wb_cyc_i && wb_stb_i));

  // The FIFO keeps its ack up until the request falls
  a_ack_held: assert property (@(posedge wb_clk) disable iff (wb_rst)
    cmd_req && cmd_ack |=> cmd_ack);

endmodule

`default_nettype wire

// ==== test/hbus_mem_model.sv ====
`default_nettype none

module hbus_mem_model #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 16,
  parameter int MEM_WORDS  = 65536,
  parameter int SEED       = 26
) (
  input  wire logic                    wb_clk,
  input  wire logic                    wb_rst,
  input  wire logic [ADDR_WIDTH-1:0]   hbus_adr_i,
  input  wire logic [DATA_WIDTH-1:0]   hbus_dat_i,
  input  wire logic [DATA_WIDTH/8-1:0] hbus_be_i,
  input  wire logic                    hbus_rrq_i,
  input  wire logic                    hbus_wrq_i,
  output logic      [DATA_WIDTH-1:0]   hbus_dat_o,
  output logic                         hbus_ready_o,
  output logic                         hbus_valid_o,
  output logic                         hbus_busy_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int BE_W  = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  int lat_left;
  int busy_left;
  bit in_beat;

  // Completes the beat that is currently requested
  task automatic finish_beat();
    logic [IDX_W-1:0] idx;
    idx = hbus_adr_i[IDX_W-1:0];
    if (hbus_wrq_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (hbus_be_i[b]) begin
          mem[idx][8*b +: 8] = hbus_dat_i[8*b +: 8];
        end
      end
      hbus_ready_o = 1'b1;
    end else begin
      hbus_dat_o   = mem[idx];
      hbus_valid_o = 1'b1;
    end
  endtask

  initial begin
    hbus_dat_o   = '0;
    hbus_ready_o = 1'b0;
    hbus_valid_o = 1'b0;
    hbus_busy_o  = 1'b0;
    in_beat      = 1'b0;
    lat_left     = 0;
    busy_left    = 0;
    void'($urandom(SEED));
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = DATA_WIDTH'(i) ^ DATA_WIDTH'('hc3a5);
    end
    forever begin
      @(posedge wb_clk);
      #1;
      // Responses are single-cycle pulses
      hbus_ready_o = 1'b0;
      hbus_valid_o = 1'b0;
      if (wb_rst) begin
        in_beat     = 1'b0;
        busy_left   = 0;
        hbus_busy_o = 1'b0;
      end else begin
        if (busy_left > 0) begin
          busy_left--;
        end else if (!in_beat && !hbus_rrq_i && !hbus_wrq_i && ($urandom % 8) == 0) begin
          busy_left = 1 + ($urandom % 3);
        end
        hbus_busy_o = (busy_left > 0);
        if ((hbus_rrq_i || hbus_wrq_i) && !in_beat) begin
          in_beat  = 1'b1;
          lat_left = $urandom % 6;
        end
        if (in_beat) begin
          if (lat_left > 0) begin
            lat_left--;
          end else begin
            finish_beat();
            in_beat = 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/hbus_stimulus.txt ====
# Columns: name op byte_addr wdata sel expected_rdata expect_err
# op is W or R, the middle four are hex, expect_err is 1 where wb_err_o must answer
full_wr        W 00000100 12345678 f 00000000 0
full_rd        R 00000100 00000000 0 12345678 0
part_base_wr   W 00000200 a1b2c3d4 f 00000000 0
part_lo_wr     W 00000200 5566ffee 5 00000000 0
part_lo_rd     R 00000200 00000000 0 a166c3ee 0
part_base2_wr  W 00000204 0f0f0f0f f 00000000 0
part_hi_wr     W 00000204 deadbeef a 00000000 0
part_hi_rd     R 00000204 00000000 0 de0fbe0f 0
burst_wr0      W 00000300 f00d0001 f 00000000 0
burst_wr1      W 00000304 f00d0012 f 00000000 0
burst_wr2      W 00000308 f00d0123 f 00000000 0
burst_wr3      W 0000030c f00d1234 f 00000000 0
burst_wr4      W 00001310 a5a55a5a f 00000000 0
burst_wr5      W 00000314 0badcafe f 00000000 0
burst_rd0      R 00000300 00000000 0 f00d0001 0
burst_rd1      R 00000304 00000000 0 f00d0012 0
burst_rd2      R 00000308 00000000 0 f00d0123 0
burst_rd3      R 0000030c 00000000 0 f00d1234 0
burst_rd4      R 00001310 00000000 0 a5a55a5a 0
burst_rd5      R 00000314 00000000 0 0badcafe 0
misalign_wr    W 00000102 ffffffff f 00000000 1
misalign_rd    R 00000101 00000000 0 00000000 1
misalign_wr3   W 00000103 ffffffff 3 00000000 1
after_err_rd   R 00000100 00000000 0 12345678 0
same_wr0       W 00000400 11111111 f 00000000 0
same_wr1       W 00000400 22222222 f 00000000 0
same_wr2       W 00000400 33333333 f 00000000 0
same_rd        R 00000400 00000000 0 33333333 0
same_part_wr   W 00000400 000000aa 1 00000000 0
same_part_rd   R 00000400 00000000 0 333333aa 0

// ==== test/tb_hbus_bridge.sv ====
`default_nettype none

module tb_hbus_bridge;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WB_DATA_WIDTH   = hbus_pkg::DEF_WB_DATA_WIDTH;
  localparam int WB_ADDR_WIDTH   = hbus_pkg::DEF_WB_ADDR_WIDTH;
  localparam int HBUS_ADDR_WIDTH = hbus_pkg::DEF_HBUS_ADDR_WIDTH;
  localparam int HBUS_DATA_WIDTH = hbus_pkg::DEF_HBUS_DATA_WIDTH;
  localparam int FIFO_DEPTH      = hbus_pkg::DEF_FIFO_DEPTH;
  localparam int TIMEOUT_CYCLES  = 200;
  localparam int RAND_SEED       = 26;

  logic                         wb_clk = 1'b0;
  logic                         wb_rst;
  logic [WB_ADDR_WIDTH-1:0]     wb_adr;
  logic [WB_DATA_WIDTH-1:0]     wb_dat_w;
  logic [WB_DATA_WIDTH-1:0]     wb_dat_r;
  logic                         wb_we;
  logic [WB_DATA_WIDTH/8-1:0]   wb_sel;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_ack;
  logic                         wb_err;
  logic [HBUS_ADDR_WIDTH-1:0]   hbus_adr;
  logic [HBUS_DATA_WIDTH-1:0]   hbus_dat_w;
  logic [HBUS_DATA_WIDTH-1:0]   hbus_dat_r;
  logic [HBUS_DATA_WIDTH/8-1:0] hbus_be;
  logic                         hbus_rrq;
  logic                         hbus_wrq;
  logic                         hbus_ready;
  logic                         hbus_valid;
  logic                         hbus_busy;

  int pass_count;
  int fail_count;

  always #2 wb_clk = ~wb_clk;

  hbus_bridge_top #(
    .WB_DATA_WIDTH   (WB_DATA_WIDTH),
    .WB_ADDR_WIDTH   (WB_ADDR_WIDTH),
    .HBUS_ADDR_WIDTH (HBUS_ADDR_WIDTH),
    .HBUS_DATA_WIDTH (HBUS_DATA_WIDTH),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) dut (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat_w),
    .wb_we_i      (wb_we),
    .wb_sel_i     (wb_sel),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_dat_o     (wb_dat_r),
    .wb_ack_o     (wb_ack),
    .wb_err_o     (wb_err),
    .hbus_adr_o   (hbus_adr),
    .hbus_dat_o   (hbus_dat_w),
    .hbus_be_o    (hbus_be),
    .hbus_rrq_o   (hbus_rrq),
    .hbus_wrq_o   (hbus_wrq),
    .hbus_dat_i   (hbus_dat_r),
    .hbus_ready_i (hbus_ready),
    .hbus_valid_i (hbus_valid),
    .hbus_busy_i  (hbus_busy)
  );

  hbus_mem_model #(
    .ADDR_WIDTH (HBUS_ADDR_WIDTH),
    .DATA_WIDTH (HBUS_DATA_WIDTH),
    .MEM_WORDS  (65536),
    .SEED       (RAND_SEED)
  ) u_mem (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .hbus_adr_i   (hbus_adr),
    .hbus_dat_i   (hbus_dat_w),
    .hbus_be_i    (hbus_be),
    .hbus_rrq_i   (hbus_rrq),
    .hbus_wrq_i   (hbus_wrq),
    .hbus_dat_o   (hbus_dat_r),
    .hbus_ready_o (hbus_ready),
    .hbus_valid_o (hbus_valid),
    .hbus_busy_o  (hbus_busy)
  );

  task automatic report_pass(input string name);
    pass_count++;
    $display("PASS %s", name);
  endtask

  // One classic Wishbone cycle, held until ack or err
  task automatic run_access(input logic is_write, input logic [31:0] adr,
                            input logic [31:0] wdat, input logic [3:0] sel,
                            output logic got_ack, output logic got_err,
                            output logic [31:0] rdat, output logic timed_out);
    int cycles;
    got_ack   = 1'b0;
    got_err   = 1'b0;
    rdat      = '0;
    timed_out = 1'b0;
    cycles    = 0;
    @(posedge wb_clk);
    #1;
    wb_adr   = adr;
    wb_dat_w = wdat;
    wb_sel   = sel;
    wb_we    = is_write;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    while (!got_ack && !got_err && !timed_out) begin
      @(posedge wb_clk);
      #1;
      if (wb_ack) begin
        got_ack = 1'b1;
        rdat    = wb_dat_r;
      end else if (wb_err) begin
        got_err = 1'b1;
      end else begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
          timed_out = 1'b1;
        end
      end
    end
    // The response is seen at the coming edge, so the bus is released after it
    @(posedge wb_clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op_str;
    logic [31:0] adr;
    logic [31:0] wdat;
    logic [31:0] exp_dat;
    logic [31:0] rdat;
    logic [3:0]  sel;
    int          exp_err;
    logic        is_write;
    logic        got_ack;
    logic        got_err;
    logic        timed_out;
    bit          aborted;

    pass_count = 0;
    fail_count = 0;
    aborted    = 1'b0;
    wb_rst     = 1'b1;
    wb_adr     = '0;
    wb_dat_w   = '0;
    wb_we      = 1'b0;
    wb_sel     = '0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    repeat (3) @(posedge wb_clk);
    #1;
    wb_rst = 1'b0;

    if (wb_ack !== 1'b0 || wb_err !== 1'b0 || hbus_rrq !== 1'b0 || hbus_wrq !== 1'b0) begin
      fail_count++;
      $display("MISMATCH reset_idle expected ack/err/rrq/wrq 0000 actual %b%b%b%b",
               wb_ack, wb_err, hbus_rrq, hbus_wrq);
    end else begin
      report_pass("reset_idle");
    end

    fd = $fopen("test/hbus_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/hbus_stimulus.txt");
      fail_count++;
      aborted = 1'b1;
    end

    while (!aborted && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %s %h %h %h %h %d", name, op_str, adr, wdat, sel, exp_dat, exp_err);
      if (n != 7 || (op_str != "W" && op_str != "R")) begin
        $display("Stimulus line could not be parsed: %s", line);
        fail_count++;
        continue;
      end
      is_write = (op_str == "W");
      run_access(is_write, adr, wdat, sel, got_ack, got_err, rdat, timed_out);
      if (timed_out) begin
        $display("%s got neither ack nor err within %0d cycles", name, TIMEOUT_CYCLES);
        fail_count++;
        aborted = 1'b1;
      end else if (exp_err != 0 && !got_err) begin
        fail_count++;
        $display("MISMATCH %s expected err actual ack", name);
      end else if (exp_err == 0 && got_err) begin
        fail_count++;
        $display("MISMATCH %s expected ack actual err", name);
      end else if (!is_write && exp_err == 0 && rdat !== exp_dat) begin
        fail_count++;
        $display("MISMATCH %s expected %h actual %h", name, exp_dat, rdat);
      end else begin
        report_pass(name);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count != 0) begin
      $display("TESTBENCH FAILED");
    end else begin
      $display("TESTBENCH PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire
